/* hdl/issue_consts.svh */
`ifndef ISSUE_CONSTS_SVH
`define ISSUE_CONSTS_SVH

// general purpose registers, r0 hard wired
`define ISSUE_NREGS 32

// scoreboard entry retires after this phase
`define ISSUE_LAST_PHASE 3

`define ISSUE_LINK_OFFSET 8 // branch + delay slot

`define ISSUE_IMM_BITS 16
`define ISSUE_SHAMT_BITS 5

`endif

/* hdl/issue_pkg.sv */
`include "issue_consts.svh"

package issue_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0] regid_t;

    localparam regid_t R0 = 5'd0;

    typedef enum logic [1:0] {U_NONE, U_ALU, U_MEMORY, U_BRANCH} unit_e;
    typedef enum logic [2:0] {FU_NONE, FU_ALU1, FU_ALU2, FU_AGU, FU_BRU} fu_e;
    typedef enum logic [1:0] {RTYPE, ITYPE, INDEX} itype_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
        ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
    } alu_op_e;

    typedef enum logic [2:0] {
        CMP_EQ, CMP_NE, CMP_LEZ, CMP_GTZ, CMP_LTZ, CMP_GEZ, CMP_ALWAYS
    } cmp_e;

    typedef struct packed {
        word_t pc;
        unit_e unit;
        itype_e itype;
        regid_t reg_a;
        regid_t reg_b;
        regid_t reg_c;
        logic read_en_a;
        logic read_en_b;
        logic write_en_c;
        word_t imm;
        logic [`ISSUE_SHAMT_BITS-1:0] shamt;
        alu_op_e alu_op;
        cmp_e cmp;
        logic mem_read;
        logic mem_write;
        word_t jump_pc;
    } decoded_instr_t;

    typedef struct packed {
        logic en;
        fu_e fu;
        regid_t target_reg;
        word_t pc;
    } exec_reg_t;

    typedef struct packed {
        logic pending;
        fu_e fu;
        logic [1:0] phase;
    } sb_entry_t;

    typedef word_t [3:1] bypass_t; // result word per phase

    typedef struct packed {
        logic en;
        word_t op_a;
        word_t op_b;
        logic [`ISSUE_SHAMT_BITS-1:0] shamt;
        alu_op_e alu_op;
    } alu_input_t;

    typedef struct packed {
        logic en;
        word_t base;
        word_t offset;
        word_t data;
        logic mem_read;
        logic mem_write;
    } agu_input_t;

    typedef struct packed {
        logic en;
        word_t op_a;
        word_t op_b;
        cmp_e cmp;
        word_t link_pc;
        word_t jump_pc;
    } bru_input_t;

endpackage

/* hdl/issue_ifs.sv */
interface issue_sel_if;
    import issue_pkg::*;

    logic [1:0] issue_cnt;
    exec_reg_t exec_reg1;
    exec_reg_t exec_reg2;
    regid_t ra1, ra2, ra3, ra4;

    modport pair (output issue_cnt, exec_reg1, exec_reg2, ra1, ra2, ra3, ra4);
    modport sb (input exec_reg1, exec_reg2);
    modport bypass (input ra1, ra2, ra3, ra4);
    modport dispatch (input exec_reg1, exec_reg2);
endinterface

// resolved operand per read port
interface operand_if;
    import issue_pkg::*;

    word_t rd1, rd2, rd3, rd4;

    modport src (output rd1, rd2, rd3, rd4);
    modport dst (input rd1, rd2, rd3, rd4);
endinterface

/* hdl/issue_pair_check.sv */
`include "issue_consts.svh"

module issue_pair_check (
    input  issue_pkg::decoded_instr_t instr0,
    input  issue_pkg::decoded_instr_t instr1,
    input  issue_pkg::sb_entry_t [`ISSUE_NREGS-1:0] scoreboard,
    input  logic queue_empty,
    input  logic mem_halt,
    issue_sel_if.pair sel
);
    import issue_pkg::*;

    logic ready0, ready1;
    logic hold, single;

    // alu_ok lets ALU producers through, they are forwarded
    function automatic logic src_busy(decoded_instr_t in, logic alu_ok);
        sb_entry_t ea;
        sb_entry_t eb;
        logic busy_a;
        logic busy_b;
        ea = scoreboard[in.reg_a];
        eb = scoreboard[in.reg_b];
        busy_a = in.read_en_a && ea.pending
            && !(alu_ok && (ea.fu == FU_ALU1 || ea.fu == FU_ALU2));
        busy_b = in.read_en_b && eb.pending
            && !(alu_ok && (eb.fu == FU_ALU1 || eb.fu == FU_ALU2));
        return busy_a || busy_b;
    endfunction

    function automatic exec_reg_t mk_exec(decoded_instr_t in, logic second);
        exec_reg_t r;
        r.en = 1'b1;
        case (in.unit)
            U_ALU:    r.fu = second ? FU_ALU2 : FU_ALU1;
            U_MEMORY: r.fu = FU_AGU;
            U_BRANCH: r.fu = FU_BRU;
            default:  r.fu = FU_NONE;
        endcase
        r.target_reg = in.write_en_c ? in.reg_c : R0;
        r.pc = in.pc;
        return r;
    endfunction

    always_comb begin
        ready0 = instr0.pc != '0 && !src_busy(instr0, 1'b1);
        ready1 = instr1.pc != '0 && !src_busy(instr1, 1'b0);
    end

    // branch never leaves without its delay slot
    assign hold = !ready0 || queue_empty || mem_halt
        || (instr0.unit == U_BRANCH && (instr1.pc == '0 || !ready1));

    assign single = !ready1
        || (instr0.unit == U_MEMORY && instr1.unit == U_MEMORY)
        || instr1.unit == U_BRANCH
        || (instr0.write_en_c && instr1.write_en_c && instr0.reg_c == instr1.reg_c)
        || (instr0.write_en_c && ((instr1.read_en_a && instr1.reg_a == instr0.reg_c)
            || (instr1.read_en_b && instr1.reg_b == instr0.reg_c)))
        || (instr1.unit == U_MEMORY && instr0.unit != U_BRANCH);

    always_comb begin
        sel.issue_cnt = 2'd0;
        sel.exec_reg1 = '0;
        sel.exec_reg2 = '0;
        sel.ra1 = R0;
        sel.ra2 = R0;
        sel.ra3 = R0;
        sel.ra4 = R0;
        if (!hold) begin
            sel.issue_cnt = single ? 2'd1 : 2'd2;
            sel.exec_reg1 = mk_exec(instr0, 1'b0);
            sel.ra1 = instr0.reg_a;
            sel.ra2 = instr0.reg_b;
            if (!single) begin
                sel.exec_reg2 = mk_exec(instr1, 1'b1);
                sel.ra3 = instr1.reg_a;
                sel.ra4 = instr1.reg_b;
            end
        end
    end

endmodule

/* hdl/issue_scoreboard.sv */
`include "issue_consts.svh"

module issue_scoreboard (
    input  logic clk,
    input  logic resetn,
    input  logic mem_halt,
    issue_sel_if.sb sel,
    output issue_pkg::sb_entry_t [`ISSUE_NREGS-1:0] scoreboard
);
    import issue_pkg::*;

    sb_entry_t [`ISSUE_NREGS-1:0] sb_nxt;

    function automatic logic hits(exec_reg_t r, int idx);
        return r.en && r.target_reg == regid_t'(idx);
    endfunction

    always_comb begin
        sb_nxt = scoreboard;
        for (int i = 1; i < `ISSUE_NREGS; i++) begin
            if (scoreboard[i].pending) begin
                if (scoreboard[i].phase == 2'(`ISSUE_LAST_PHASE))
                    sb_nxt[i] = '0;
                else
                    sb_nxt[i].phase = scoreboard[i].phase + 2'd1;
            end
            // new producers override aging
            if (hits(sel.exec_reg1, i)) begin
                sb_nxt[i].pending = 1'b1;
                sb_nxt[i].fu = sel.exec_reg1.fu;
                sb_nxt[i].phase = 2'd1;
            end
            if (hits(sel.exec_reg2, i)) begin
                sb_nxt[i].pending = 1'b1;
                sb_nxt[i].fu = sel.exec_reg2.fu;
                sb_nxt[i].phase = 2'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn)
            scoreboard <= '0;
        else if (!mem_halt) // frozen while memory stalls
            scoreboard <= sb_nxt;
    end

endmodule

/* hdl/operand_bypass.sv */
`include "issue_consts.svh"

module operand_bypass (
    issue_sel_if.bypass sel,
    input  issue_pkg::sb_entry_t [`ISSUE_NREGS-1:0] scoreboard,
    input  issue_pkg::word_t rd1_reg,
    input  issue_pkg::word_t rd2_reg,
    input  issue_pkg::word_t rd3_reg,
    input  issue_pkg::word_t rd4_reg,
    input  issue_pkg::bypass_t alu1_bypass,
    input  issue_pkg::bypass_t alu2_bypass,
    operand_if.src opd
);
    import issue_pkg::*;

    // phase tells how far down the ALU pipe the result sits
    function automatic word_t pick(regid_t ra, word_t rf);
        sb_entry_t e;
        word_t res;
        e = scoreboard[ra];
        res = rf;
        if (e.pending) begin
            if (e.fu == FU_ALU1)
                res = alu1_bypass[e.phase];
            else if (e.fu == FU_ALU2)
                res = alu2_bypass[e.phase];
        end
        return res;
    endfunction

    always_comb begin
        opd.rd1 = pick(sel.ra1, rd1_reg);
        opd.rd2 = pick(sel.ra2, rd2_reg);
        opd.rd3 = pick(sel.ra3, rd3_reg);
        opd.rd4 = pick(sel.ra4, rd4_reg);
    end

endmodule

/* hdl/unit_dispatch.sv */
`include "issue_consts.svh"

module unit_dispatch (
    input  issue_pkg::decoded_instr_t instr0,
    input  issue_pkg::decoded_instr_t instr1,
    issue_sel_if.dispatch sel,
    operand_if.dst opd,
    output issue_pkg::alu_input_t alu1_input,
    output issue_pkg::alu_input_t alu2_input,
    output issue_pkg::agu_input_t agu_input,
    output issue_pkg::bru_input_t bru_input
);
    import issue_pkg::*;

    function automatic alu_input_t mk_alu(decoded_instr_t in, word_t ra, word_t rb);
        alu_input_t b;
        b.en = 1'b1;
        b.op_a = ra;
        b.op_b = in.itype == ITYPE ? in.imm : rb;
        b.shamt = in.read_en_b ? rb[`ISSUE_SHAMT_BITS-1:0] : in.shamt; // variable shifts
        b.alu_op = in.alu_op;
        return b;
    endfunction

    function automatic agu_input_t mk_agu(decoded_instr_t in, word_t ra, word_t rb);
        agu_input_t b;
        b.en = 1'b1;
        b.base = ra;
        b.offset = {{(32-`ISSUE_IMM_BITS){in.imm[`ISSUE_IMM_BITS-1]}},
                    in.imm[`ISSUE_IMM_BITS-1:0]};
        b.data = rb; // store data
        b.mem_read = in.mem_read;
        b.mem_write = in.mem_write;
        return b;
    endfunction

    function automatic bru_input_t mk_bru(decoded_instr_t in, word_t ra, word_t rb);
        bru_input_t b;
        b.en = 1'b1;
        b.op_a = ra;
        b.op_b = rb;
        b.cmp = in.cmp;
        b.link_pc = in.pc + 32'(`ISSUE_LINK_OFFSET);
        case (in.itype)
            INDEX:   b.jump_pc = in.imm;
            RTYPE:   b.jump_pc = ra; // jr / jalr
            default: b.jump_pc = in.jump_pc;
        endcase
        return b;
    endfunction

    always_comb begin
        alu1_input = '0;
        alu2_input = '0;
        agu_input = '0;
        bru_input = '0;
        case (sel.exec_reg1.fu)
            FU_ALU1: alu1_input = mk_alu(instr0, opd.rd1, opd.rd2);
            FU_AGU:  agu_input = mk_agu(instr0, opd.rd1, opd.rd2);
            FU_BRU:  bru_input = mk_bru(instr0, opd.rd1, opd.rd2);
            default: ;
        endcase
        // slot 1 never carries a branch
        case (sel.exec_reg2.fu)
            FU_ALU2: alu2_input = mk_alu(instr1, opd.rd3, opd.rd4);
            FU_AGU:  agu_input = mk_agu(instr1, opd.rd3, opd.rd4);
            default: ;
        endcase
    end

endmodule

/* hdl/issue_top.sv */
`include "issue_consts.svh"

module issue_top (
    input  logic clk,
    input  logic resetn,
    input  logic queue_empty,
    input  logic mem_halt,
    input  issue_pkg::decoded_instr_t instr0,
    input  issue_pkg::decoded_instr_t instr1,
    input  issue_pkg::word_t rd1_reg,
    input  issue_pkg::word_t rd2_reg,
    input  issue_pkg::word_t rd3_reg,
    input  issue_pkg::word_t rd4_reg,
    input  issue_pkg::bypass_t alu1_bypass,
    input  issue_pkg::bypass_t alu2_bypass,
    output logic [1:0] issue_cnt,
    output issue_pkg::regid_t ra1,
    output issue_pkg::regid_t ra2,
    output issue_pkg::regid_t ra3,
    output issue_pkg::regid_t ra4,
    output issue_pkg::exec_reg_t exec_reg1,
    output issue_pkg::exec_reg_t exec_reg2,
    output issue_pkg::alu_input_t alu1_input,
    output issue_pkg::alu_input_t alu2_input,
    output issue_pkg::agu_input_t agu_input,
    output issue_pkg::bru_input_t bru_input
);
    import issue_pkg::*;

    sb_entry_t [`ISSUE_NREGS-1:0] scoreboard;

    issue_sel_if sel_if ();
    operand_if opd_if ();

    issue_pair_check pair0 (
        .instr0(instr0), .instr1(instr1), .scoreboard(scoreboard),
        .queue_empty(queue_empty), .mem_halt(mem_halt), .sel(sel_if.pair)
    );

    issue_scoreboard sb0 (
        .clk(clk), .resetn(resetn), .mem_halt(mem_halt),
        .sel(sel_if.sb), .scoreboard(scoreboard)
    );

    operand_bypass byp0 (
        .sel(sel_if.bypass), .scoreboard(scoreboard),
        .rd1_reg(rd1_reg), .rd2_reg(rd2_reg), .rd3_reg(rd3_reg), .rd4_reg(rd4_reg),
        .alu1_bypass(alu1_bypass), .alu2_bypass(alu2_bypass), .opd(opd_if.src)
    );

    unit_dispatch disp0 (
        .instr0(instr0), .instr1(instr1), .sel(sel_if.dispatch), .opd(opd_if.dst),
        .alu1_input(alu1_input), .alu2_input(alu2_input),
        .agu_input(agu_input), .bru_input(bru_input)
    );

    assign issue_cnt = sel_if.issue_cnt;
    assign exec_reg1 = sel_if.exec_reg1;
    assign exec_reg2 = sel_if.exec_reg2;
    assign ra1 = sel_if.ra1;
    assign ra2 = sel_if.ra2;
    assign ra3 = sel_if.ra3;
    assign ra4 = sel_if.ra4;

endmodule

/* testbench/issue_sva.sv */
module issue_sva (
    input logic clk,
    input logic resetn,
    input logic mem_halt,
    input logic [1:0] issue_cnt,
    input issue_pkg::exec_reg_t exec_reg1,
    input issue_pkg::exec_reg_t exec_reg2,
    input issue_pkg::alu_input_t alu1_input,
    input issue_pkg::alu_input_t alu2_input,
    input issue_pkg::agu_input_t agu_input,
    input issue_pkg::bru_input_t bru_input
);

    cnt_range: assert property (@(posedge clk) disable iff (!resetn) issue_cnt != 2'd3)
        else $error("issue_cnt reached 3");

    // slot 1 only goes together with slot 0
    slot_order: assert property (@(posedge clk) disable iff (!resetn)
        exec_reg2.en |-> exec_reg1.en)
        else $error("slot 1 issued without slot 0");

    halt_quiet: assert property (@(posedge clk) disable iff (!resetn)
        mem_halt |-> !(alu1_input.en || alu2_input.en || agu_input.en || bru_input.en))
        else $error("unit enable set during mem_halt");

endmodule

bind issue_top issue_sva sva0 (
    .clk(clk), .resetn(resetn), .mem_halt(mem_halt), .issue_cnt(issue_cnt),
    .exec_reg1(exec_reg1), .exec_reg2(exec_reg2),
    .alu1_input(alu1_input), .alu2_input(alu2_input),
    .agu_input(agu_input), .bru_input(bru_input)
);

/* testbench/issue_tb.sv */
module issue_tb;
    import issue_pkg::*;

    localparam int MAX_CYCLES = 200; // tests need about 70 cycles with reset

    logic clk = 1'b0;
    logic resetn, queue_empty, mem_halt;
    decoded_instr_t instr0, instr1;
    word_t rd1_reg, rd2_reg, rd3_reg, rd4_reg;
    bypass_t alu1_bypass, alu2_bypass;
    logic [1:0] issue_cnt;
    regid_t ra1, ra2, ra3, ra4;
    exec_reg_t exec_reg1, exec_reg2;
    alu_input_t alu1_input, alu2_input;
    agu_input_t agu_input;
    bru_input_t bru_input;
    decoded_instr_t bubble = '0; // pc zero marks an empty slot
    int seed = 32'h685f;
    int cycles = 0;
    int checks = 0;
    int errors = 0;

    issue_top dut0 (.*);

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == MAX_CYCLES) begin
            $display("timeout: tests did not finish within %0d cycles", MAX_CYCLES);
            $display(">>> FAIL");
            $finish;
        end
    end

    function automatic word_t rand_word();
        return $random(seed);
    endfunction

    // base register so that base..base+6 stay inside r1..r30
    function automatic regid_t rand_base();
        return regid_t'(1 + {$random(seed)} % 24);
    endfunction

    function automatic decoded_instr_t mk(word_t pc, unit_e unit, itype_e t,
                                          regid_t a, regid_t b, regid_t c, word_t imm);
        decoded_instr_t d;
        d = '0;
        d.pc = pc;
        d.unit = unit;
        d.itype = t;
        d.reg_a = a;
        d.reg_b = b;
        d.reg_c = c;
        d.read_en_a = a != R0;
        d.read_en_b = b != R0;
        d.write_en_c = c != R0;
        d.imm = imm;
        d.mem_read = unit == U_MEMORY && c != R0; // load writes, store does not
        d.mem_write = unit == U_MEMORY && c == R0;
        return d;
    endfunction

    task automatic drive(decoded_instr_t i0, decoded_instr_t i1, logic halt, logic empty);
        @(posedge clk);
        instr0 <= i0;
        instr1 <= i1;
        mem_halt <= halt;
        queue_empty <= empty;
        @(negedge clk); // outputs settled, sample here
    endtask

    task automatic idle(int n);
        repeat (n) drive(bubble, bubble, 1'b0, 1'b0);
    endtask

    task automatic check(word_t got, word_t exp, string what);
        checks++;
        assert (got === exp)
        else begin
            errors++;
            $display("MISMATCH t=%0t %s: got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic test_dual_issue();
        regid_t b;
        word_t imm;
        b = rand_base();
        imm = rand_word();
        drive(mk(32'h100, U_ALU, RTYPE, b, b + 1, b + 2, '0),
              mk(32'h104, U_ALU, RTYPE, b + 3, b + 4, b + 5, '0), 1'b0, 1'b0);
        check(issue_cnt, 2, "dual issue count");
        check(exec_reg1.fu, FU_ALU1, "slot 0 unit");
        check(exec_reg2.fu, FU_ALU2, "slot 1 unit");
        check(exec_reg2.target_reg, b + 5, "slot 1 target");
        check(ra1, b, "ra1 slot 0 reg_a");
        check(ra2, b + 1, "ra2 slot 0 reg_b");
        check(ra3, b + 3, "ra3 slot 1 reg_a");
        check(ra4, b + 4, "ra4 slot 1 reg_b");
        check(alu2_input.op_b, rd4_reg, "alu2 op_b rtype");
        drive(mk(32'h108, U_ALU, RTYPE, b + 3, b + 4, b + 6, '0),
              mk(32'h10c, U_ALU, ITYPE, b, R0, b + 1, imm), 1'b0, 1'b0);
        check(issue_cnt, 2, "dual issue with itype");
        check(alu2_input.op_b, imm, "alu2 op_b itype");
    endtask

    // sources b and b+1 are never written here
    task automatic test_pairing();
        regid_t b;
        b = rand_base();
        idle(4);
        drive(mk(32'h300, U_MEMORY, ITYPE, b, R0, b + 2, 32'h4),
              mk(32'h304, U_MEMORY, ITYPE, b, R0, b + 3, 32'h8), 1'b0, 1'b0);
        check(issue_cnt, 1, "two memory ops");
        drive(mk(32'h308, U_ALU, RTYPE, b, b + 1, b + 4, '0),
              mk(32'h30c, U_BRANCH, ITYPE, b, b + 1, R0, '0), 1'b0, 1'b0);
        check(issue_cnt, 1, "branch in slot 1");
        drive(mk(32'h310, U_ALU, RTYPE, b, b + 1, b + 5, '0),
              mk(32'h314, U_ALU, RTYPE, b, b + 1, b + 5, '0), 1'b0, 1'b0);
        check(issue_cnt, 1, "same destination");
        check(ra3, R0, "ra3 on single issue");
        check(ra4, R0, "ra4 on single issue");
        drive(mk(32'h318, U_ALU, RTYPE, b, b + 1, b + 6, '0),
              mk(32'h31c, U_ALU, RTYPE, b + 6, b, b + 3, '0), 1'b0, 1'b0);
        check(issue_cnt, 1, "slot 1 reads slot 0 destination");
        drive(mk(32'h320, U_BRANCH, ITYPE, b, b + 1, R0, '0), bubble, 1'b0, 1'b0);
        check(issue_cnt, 0, "branch without delay slot");
    endtask

    task automatic test_load_use(int halt);
        regid_t b;
        decoded_instr_t use_i;
        b = rand_base();
        use_i = mk(32'h204, U_ALU, RTYPE, b + 1, b + 2, b + 3, '0);
        idle(4);
        drive(mk(32'h200, U_MEMORY, ITYPE, b, R0, b + 1, 32'h10), bubble, 1'b0, 1'b0);
        check(issue_cnt, 1, "load issue");
        for (int k = 0; k < 3 + halt; k++) begin
            drive(use_i, bubble, k >= 1 && k <= halt, 1'b0); // halt after first stall
            check(issue_cnt, 0, "load-use stall");
        end
        drive(use_i, bubble, 1'b0, 1'b0);
        check(issue_cnt, 1, "load-use release");
    endtask

    task automatic test_forwarding();
        regid_t b;
        decoded_instr_t use_i;
        b = rand_base();
        use_i = mk(32'h404, U_ALU, RTYPE, b + 1, b + 2, b + 3, '0);
        idle(4);
        drive(mk(32'h400, U_ALU, RTYPE, b + 4, b + 5, b + 1, '0), bubble, 1'b0, 1'b0);
        check(issue_cnt, 1, "producer issue");
        for (int p = 1; p <= 3; p++) begin
            drive(use_i, bubble, 1'b0, 1'b0);
            check(issue_cnt, 1, "consumer issue");
            check(alu1_input.op_a, alu1_bypass[p], "alu1 forwarded op_a");
        end
    endtask

    task automatic test_bundles();
        regid_t b;
        b = rand_base();
        idle(4);
        drive(mk(32'h500, U_MEMORY, ITYPE, b, R0, b + 1, 32'h1234_8004), bubble, 1'b0, 1'b0);
        check(agu_input.offset, 32'hffff_8004, "agu negative offset");
        drive(mk(32'h504, U_MEMORY, ITYPE, b, b + 2, R0, 32'hfedc_1230), bubble, 1'b0, 1'b0);
        check(agu_input.offset, 32'h0000_1230, "agu positive offset");
        check(agu_input.data, rd2_reg, "agu store data");
        drive(mk(32'h508, U_BRANCH, INDEX, R0, R0, R0, 32'h0040_0000),
              mk(32'h50c, U_ALU, RTYPE, b + 3, b + 4, b + 5, '0), 1'b0, 1'b0);
        check(issue_cnt, 2, "branch with delay slot");
        check(bru_input.link_pc, 32'h508 + 8, "bru link_pc");
        check(bru_input.jump_pc, 32'h0040_0000, "bru index target");
        drive(mk(32'h510, U_BRANCH, RTYPE, b + 2, R0, R0, '0),
              mk(32'h514, U_ALU, RTYPE, b + 3, b + 4, b + 5, '0), 1'b0, 1'b0);
        check(bru_input.jump_pc, rd1_reg, "bru register target");
    endtask

    task automatic test_stall_empty();
        regid_t b;
        decoded_instr_t alu_i;
        b = rand_base();
        alu_i = mk(32'h600, U_ALU, RTYPE, b, b + 1, b + 2, '0);
        idle(4);
        drive(alu_i, bubble, 1'b1, 1'b0);
        check(issue_cnt, 0, "mem_halt blocks issue");
        drive(alu_i, bubble, 1'b0, 1'b1);
        check(issue_cnt, 0, "queue_empty blocks issue");
        drive(alu_i, bubble, 1'b0, 1'b0);
        check(issue_cnt, 1, "issue resumes");
        test_load_use(2);
    endtask

    initial begin
        resetn = 1'b0;
        queue_empty = 1'b1;
        mem_halt = 1'b0;
        instr0 = '0;
        instr1 = '0;
        rd1_reg = rand_word();
        rd2_reg = rand_word();
        rd3_reg = rand_word();
        rd4_reg = rand_word();
        for (int p = 1; p <= 3; p++) begin
            alu1_bypass[p] = rand_word();
            alu2_bypass[p] = rand_word();
        end
        repeat (10) @(posedge clk);
        resetn <= 1'b1;
        test_dual_issue();
        test_pairing();
        test_load_use(0);
        test_forwarding();
        test_bundles();
        test_stall_empty();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

/* project.f */
+incdir+hdl
hdl/issue_pkg.sv
hdl/issue_ifs.sv
hdl/issue_pair_check.sv
hdl/issue_scoreboard.sv
hdl/operand_bypass.sv
hdl/unit_dispatch.sv
hdl/issue_top.sv
testbench/issue_sva.sv
testbench/issue_tb.sv

/* Makefile */
.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench, check sim.log"
	@echo "make clean  remove build output and log"
	@echo "make help   show this list"

test:
	verilator --binary --assert -Wno-fatal -f project.f --top-module issue_tb -Mdir obj_dir
	./obj_dir/Vissue_tb > sim.log 2>&1 || echo ">>> FAIL" >> sim.log
	@cat sim.log
	@! grep -q ">>> FAIL" sim.log

clean:
	rm -rf obj_dir sim.log
